/* verilog/edge_data_pkg.sv */
////////////////////
// Shared definitions for the edge-data read path
// Widths of vertex, address, data and cache-line fields
// Buffer depths and almost-full margin
// Read command codes and configure-field positions
////////////////////

package edge_data_pkg;

	typedef logic [31:0]  vertex_id_t;
	typedef logic [63:0]  address_t;
	typedef logic [31:0]  data_word_t;
	typedef logic [511:0] cacheline_t;
	typedef logic [3:0]   word_offset_t;
	typedef logic [63:0]  configure_t;
	typedef logic [7:0]   cu_id_t;

	// Encodings follow the host bus read commands
	typedef enum logic [12:0] {
		READ_CL_NA = 13'h0A00,
		READ_CL_S  = 13'h0A50
	} command_code_t;

	////////////////////
	// Address formatting
	////////////////////

	localparam int       DATA_SIZE_READ     = 4;
	localparam int       CACHELINE_BYTES    = 64;
	localparam address_t ADDRESS_ALIGN_MASK = ~address_t'(CACHELINE_BYTES - 1);

	////////////////////
	// Buffers
	////////////////////

	localparam int JOB_BUFFER_DEPTH     = 16;
	localparam int BUFFER_ALFULL_MARGIN = 4;
	localparam int BUFFER_PTR_WIDTH     = $clog2(JOB_BUFFER_DEPTH);

	// Command entry is the widest payload
	localparam int BUFFER_WIDTH = $bits(command_code_t) + $bits(vertex_id_t) + $bits(address_t);

	typedef logic [BUFFER_PTR_WIDTH-1:0] buffer_ptr_t;
	typedef logic [BUFFER_PTR_WIDTH:0]   buffer_count_t;

	// Compute unit identity and configure fields
	localparam cu_id_t CU_ID          = 8'd1;
	localparam int     CFG_SHARED_BIT = 13;

endpackage

/* verilog/sync_fifo.sv */
////////////////////
// sync_fifo
// First-word-fall-through register buffer
// Full, almost-full and empty levels plus a pop valid strobe
////////////////////

`timescale 1ns/10ps

module sync_fifo (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 push,
	input  logic [edge_data_pkg::BUFFER_WIDTH-1:0] data_in,
	input  logic                                 pop,
	output logic [edge_data_pkg::BUFFER_WIDTH-1:0] data_out,
	output logic                                 valid,
	output logic                                 full,
	output logic                                 alfull,
	output logic                                 empty
);
	import edge_data_pkg::*;

	logic [BUFFER_WIDTH-1:0] mem [JOB_BUFFER_DEPTH];
	buffer_ptr_t             wr_ptr;
	buffer_ptr_t             rd_ptr;
	buffer_count_t           count;
	logic                    do_push;
	logic                    do_pop;

	// Ignore pushes when full and pops when empty
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage array
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Head is visible before the pop
	assign data_out = mem[rd_ptr];
	assign valid    = do_pop;
	assign empty    = (count == '0);
	assign full     = (count == buffer_count_t'(JOB_BUFFER_DEPTH));
	// Fewer than the margin of slots left
	assign alfull   = (count > buffer_count_t'(JOB_BUFFER_DEPTH - BUFFER_ALFULL_MARGIN));

endmodule

/* verilog/edge_data_control.sv */
////////////////////
// edge_data_control
// Enable and configure capture
// Edge job buffer and read command formatting
// Command buffer with bus request and grant
////////////////////

`timescale 1ns/10ps

module edge_data_control (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  edge_data_pkg::configure_t     cu_configure,
	input  logic                          wed_base_valid,
	input  edge_data_pkg::address_t       wed_base,
	input  logic                          edge_job_valid,
	input  edge_data_pkg::vertex_id_t     edge_job_dest,
	output logic                          edge_request,
	input  logic                          read_command_bus_grant,
	output logic                          read_command_bus_request,
	output logic                          read_command_valid,
	output edge_data_pkg::address_t       read_command_address,
	output edge_data_pkg::command_code_t  read_command_code,
	output edge_data_pkg::vertex_id_t     read_command_tag,
	output edge_data_pkg::cu_id_t         read_command_cu_id
);
	import edge_data_pkg::*;

	logic                          enabled;
	logic                          cmd_enable;
	configure_t                    cfg_latched;
	logic                          wed_base_valid_r;
	address_t                      wed_base_r;
	logic                          job_valid_r;
	vertex_id_t                    job_dest_r;
	logic                          grant_r;

	logic [BUFFER_WIDTH-1:0]       job_head;
	logic                          job_pop;
	logic                          job_valid;
	logic                          job_alfull;
	logic                          job_empty;
	vertex_id_t                    job_dest;

	logic                          cmd_push;
	address_t                      cmd_address;
	command_code_t                 cmd_code;
	vertex_id_t                    cmd_tag;

	logic [BUFFER_WIDTH-1:0]       cmd_head;
	logic                          cmd_valid;
	logic                          cmd_alfull;
	logic                          cmd_empty;
	address_t                      cmd_head_address;
	vertex_id_t                    cmd_head_tag;
	logic [$bits(command_code_t)-1:0] cmd_head_code;

	////////////////////
	// Enable and inputs
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled          <= 1'b0;
			cmd_enable       <= 1'b0;
			cfg_latched      <= '0;
			wed_base_valid_r <= 1'b0;
			job_valid_r      <= 1'b0;
			grant_r          <= 1'b0;
		end else begin
			enabled          <= enabled_in;
			cmd_enable       <= enabled && (|cfg_latched) && wed_base_valid_r;
			wed_base_valid_r <= wed_base_valid;
			job_valid_r      <= edge_job_valid;
			grant_r          <= read_command_bus_grant;
			// A zero word keeps the last setting
			if (|cu_configure)
				cfg_latched <= cu_configure;
		end
	end

	always_ff @(posedge clock) begin
		wed_base_r <= wed_base;
		job_dest_r <= edge_job_dest;
	end

	////////////////////
	// Edge job buffer
	////////////////////

	assign edge_request = enabled && !job_alfull;
	assign job_pop      = cmd_enable && !job_empty && !cmd_alfull;
	assign job_dest     = job_head[$bits(vertex_id_t)-1:0];

	sync_fifo job_buffer_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (job_valid_r),
		.data_in  (BUFFER_WIDTH'(job_dest_r)),
		.pop      (job_pop),
		.data_out (job_head),
		.valid    (job_valid),
		.full     (),
		.alfull   (job_alfull),
		.empty    (job_empty)
	);

	////////////////////
	// Command formatting
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_push <= 1'b0;
		else
			cmd_push <= job_valid;
	end

	// Cache line holding the vertex word
	always_ff @(posedge clock) begin
		if (job_valid) begin
			cmd_address <= wed_base_r +
				((address_t'(job_dest) << $clog2(DATA_SIZE_READ)) & ADDRESS_ALIGN_MASK);
			cmd_tag     <= job_dest;
			cmd_code    <= cfg_latched[CFG_SHARED_BIT] ? READ_CL_S : READ_CL_NA;
		end
	end

	////////////////////
	// Command buffer
	////////////////////

	assign read_command_bus_request = !cmd_empty;
	assign {cmd_head_code, cmd_head_tag, cmd_head_address} = cmd_head;

	sync_fifo command_buffer_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (cmd_push),
		.data_in  ({cmd_code, cmd_tag, cmd_address}),
		.pop      (grant_r),
		.data_out (cmd_head),
		.valid    (cmd_valid),
		.full     (),
		.alfull   (cmd_alfull),
		.empty    (cmd_empty)
	);

	// Head registered onto the bus
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			read_command_valid <= 1'b0;
		else
			read_command_valid <= cmd_valid;
	end

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			read_command_address <= cmd_head_address;
			read_command_tag     <= cmd_head_tag;
			read_command_code    <= command_code_t'(cmd_head_code);
			read_command_cu_id   <= CU_ID;
		end
	end

endmodule

/* verilog/edge_data_response.sv */
////////////////////
// edge_data_response
// Vertex word selection from returned cache lines
// Data buffer drained on consumer request
////////////////////

`timescale 1ns/10ps

module edge_data_response (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       read_response_valid,
	input  edge_data_pkg::vertex_id_t  read_response_tag,
	input  edge_data_pkg::cacheline_t  read_response_data,
	input  logic                       edge_data_request,
	output logic                       edge_data_valid,
	output edge_data_pkg::vertex_id_t  edge_data_dest,
	output edge_data_pkg::data_word_t  edge_data_word,
	output logic                       data_buffer_empty,
	output logic                       data_buffer_alfull
);
	import edge_data_pkg::*;

	logic                    resp_valid_r;
	vertex_id_t              resp_tag_r;
	data_word_t              resp_word_r;
	word_offset_t            resp_offset;
	logic                    pop_r;
	logic [BUFFER_WIDTH-1:0] data_head;
	logic                    data_valid;

	// Word position inside the line comes from the low tag bits
	assign resp_offset = word_offset_t'(read_response_tag);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid_r <= 1'b0;
			pop_r        <= 1'b0;
		end else begin
			resp_valid_r <= read_response_valid;
			// Requests against an empty buffer are dropped
			pop_r        <= edge_data_request && !data_buffer_empty;
		end
	end

	always_ff @(posedge clock) begin
		resp_tag_r  <= read_response_tag;
		resp_word_r <= read_response_data[resp_offset*$bits(data_word_t) +: $bits(data_word_t)];
	end

	////////////////////
	// Data buffer
	////////////////////

	sync_fifo data_buffer_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (resp_valid_r),
		.data_in  (BUFFER_WIDTH'({resp_tag_r, resp_word_r})),
		.pop      (pop_r),
		.data_out (data_head),
		.valid    (data_valid),
		.full     (),
		.alfull   (data_buffer_alfull),
		.empty    (data_buffer_empty)
	);

	// Output register toward the consumer
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			edge_data_valid <= 1'b0;
		else
			edge_data_valid <= data_valid;
	end

	always_ff @(posedge clock) begin
		if (data_valid) begin
			edge_data_dest <= data_head[$bits(data_word_t) +: $bits(vertex_id_t)];
			edge_data_word <= data_head[$bits(data_word_t)-1:0];
		end
	end

endmodule

/* verilog/cu_edge_data_top.sv */
////////////////////
// cu_edge_data_top
// Edge-data read path of one compute unit
// Command side and response side joined at the memory ports
////////////////////

`timescale 1ns/10ps

module cu_edge_data_top (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  edge_data_pkg::configure_t     cu_configure,
	input  logic                          wed_base_valid,
	input  edge_data_pkg::address_t       wed_base,
	input  logic                          edge_job_valid,
	input  edge_data_pkg::vertex_id_t     edge_job_dest,
	output logic                          edge_request,
	input  logic                          read_command_bus_grant,
	output logic                          read_command_bus_request,
	output logic                          read_command_valid,
	output edge_data_pkg::address_t       read_command_address,
	output edge_data_pkg::command_code_t  read_command_code,
	output edge_data_pkg::vertex_id_t     read_command_tag,
	output edge_data_pkg::cu_id_t         read_command_cu_id,
	input  logic                          read_response_valid,
	input  edge_data_pkg::vertex_id_t     read_response_tag,
	input  edge_data_pkg::cacheline_t     read_response_data,
	input  logic                          edge_data_request,
	output logic                          edge_data_valid,
	output edge_data_pkg::vertex_id_t     edge_data_dest,
	output edge_data_pkg::data_word_t     edge_data_word,
	output logic                          data_buffer_empty,
	output logic                          data_buffer_alfull
);

	// Jobs to read commands
	edge_data_control control_i (
		.clock                    (clock),
		.rstn                     (rstn),
		.enabled_in               (enabled_in),
		.cu_configure             (cu_configure),
		.wed_base_valid           (wed_base_valid),
		.wed_base                 (wed_base),
		.edge_job_valid           (edge_job_valid),
		.edge_job_dest            (edge_job_dest),
		.edge_request             (edge_request),
		.read_command_bus_grant   (read_command_bus_grant),
		.read_command_bus_request (read_command_bus_request),
		.read_command_valid       (read_command_valid),
		.read_command_address     (read_command_address),
		.read_command_code        (read_command_code),
		.read_command_tag         (read_command_tag),
		.read_command_cu_id       (read_command_cu_id)
	);

	// Cache lines to edge data
	edge_data_response response_i (
		.clock               (clock),
		.rstn                (rstn),
		.read_response_valid (read_response_valid),
		.read_response_tag   (read_response_tag),
		.read_response_data  (read_response_data),
		.edge_data_request   (edge_data_request),
		.edge_data_valid     (edge_data_valid),
		.edge_data_dest      (edge_data_dest),
		.edge_data_word      (edge_data_word),
		.data_buffer_empty   (data_buffer_empty),
		.data_buffer_alfull  (data_buffer_alfull)
	);

endmodule

/* sim/cu_edge_data_assertions.sv */
////////////////////
// Concurrent checks bound to the edge-data top
// Reset levels and grant to command timing
// Buffer overflow and requests on an empty data buffer
////////////////////

`timescale 1ns/10ps

module cu_edge_data_assertions (
	input logic clock,
	input logic rstn,
	input logic edge_request,
	input logic read_command_bus_request,
	input logic read_command_bus_grant,
	input logic read_command_valid,
	input logic edge_data_request,
	input logic edge_data_valid,
	input logic data_buffer_empty,
	input logic job_push,
	input logic job_full,
	input logic cmd_push,
	input logic cmd_full,
	input logic data_push,
	input logic data_full
);

	int failure_count = 0;

	// Outputs quiet while reset is held
	reset_quiet: assert property (@(posedge clock)
		!rstn |-> !edge_request && !read_command_bus_request &&
			!read_command_valid && !edge_data_valid)
		else begin
			failure_count++;
			$error("Request or valid raised during reset");
		end

	// Command leaves the bus register two cycles after its grant
	grant_to_command: assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |-> $past(read_command_bus_grant, 2))
		else begin
			failure_count++;
			$error("Read command without a grant two cycles earlier");
		end

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		!(job_push && job_full) && !(cmd_push && cmd_full) && !(data_push && data_full))
		else begin
			failure_count++;
			$error("Push into a full buffer");
		end

	empty_request_quiet: assert property (@(posedge clock) disable iff (!rstn)
		edge_data_request && data_buffer_empty |-> ##2 !edge_data_valid)
		else begin
			failure_count++;
			$error("Edge data returned for a request on an empty buffer");
		end

endmodule

bind cu_edge_data_top cu_edge_data_assertions assertions_i (
	.clock                    (clock),
	.rstn                     (rstn),
	.edge_request             (edge_request),
	.read_command_bus_request (read_command_bus_request),
	.read_command_bus_grant   (read_command_bus_grant),
	.read_command_valid       (read_command_valid),
	.edge_data_request        (edge_data_request),
	.edge_data_valid          (edge_data_valid),
	.data_buffer_empty        (data_buffer_empty),
	.job_push                 (control_i.job_buffer_i.push),
	.job_full                 (control_i.job_buffer_i.full),
	.cmd_push                 (control_i.command_buffer_i.push),
	.cmd_full                 (control_i.command_buffer_i.full),
	.data_push                (response_i.data_buffer_i.push),
	.data_full                (response_i.data_buffer_i.full)
);

/* sim/tb_cu_edge_data.sv */
////////////////////
// Testbench for the edge-data read path
// Clock, reset, job source, bus grant and memory model
// Reference word function and in-order compare of edge data
// Data buffer level model
// Cycle-count timeout
////////////////////

`timescale 1ns/10ps

module tb_cu_edge_data;
	import edge_data_pkg::*;

	localparam int       MAX_JOBS       = 115;
	localparam int       TIMEOUT_CYCLES = MAX_JOBS * 40 + 500;
	localparam address_t BASE_ADDRESS   = 64'h0000_0042_1000_0000;

	logic          clock;
	logic          rstn;
	logic          enabled_in;
	configure_t    cu_configure;
	logic          wed_base_valid;
	address_t      wed_base;
	logic          edge_job_valid;
	vertex_id_t    edge_job_dest;
	logic          edge_request;
	logic          read_command_bus_grant;
	logic          read_command_bus_request;
	logic          read_command_valid;
	address_t      read_command_address;
	command_code_t read_command_code;
	vertex_id_t    read_command_tag;
	cu_id_t        read_command_cu_id;
	logic          read_response_valid;
	vertex_id_t    read_response_tag;
	cacheline_t    read_response_data;
	logic          edge_data_request;
	logic          edge_data_valid;
	vertex_id_t    edge_data_dest;
	data_word_t    edge_data_word;
	logic          data_buffer_empty;
	logic          data_buffer_alfull;

	integer        seed;
	int            cycle_count;
	int            jobs_sent;
	int            data_seen;
	int            data_level;
	logic          resp_seen_d1;
	logic          resp_seen_d2;
	logic          grant_enable;
	logic          drain_enable;
	logic          saw_edge_request_low;
	command_code_t exp_code;
	string         test_name;
	vertex_id_t    cmd_exp_q[$];
	vertex_id_t    data_exp_q[$];
	vertex_id_t    mem_tag_q[$];
	address_t      mem_addr_q[$];
	int            mem_due_q[$];

	cu_edge_data_top dut_i (.*);

	////////////////////
	// Memory contents and reference
	////////////////////

	// Fixed hash of the byte address
	function automatic data_word_t mem_word(address_t addr);
		data_word_t h;
		h = addr[31:0] ^ (addr[63:32] * 32'h85eb_ca6b);
		h = h * 32'h9e37_79b1;
		h = h ^ (h >> 15) ^ addr[33:2];
		return h;
	endfunction

	function automatic cacheline_t build_line(address_t addr);
		cacheline_t line;
		for (int i = 0; i < 16; i++)
			line[i*32 +: 32] = mem_word(addr + address_t'(4 * i));
		return line;
	endfunction

	function automatic data_word_t expected_word(address_t base, vertex_id_t dest);
		return mem_word(base + (address_t'(dest) << 2));
	endfunction

	////////////////////
	// Failure reporting
	////////////////////

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(string field, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual)
			fail_run($sformatf("[ERROR] %s: %s expected %0h, actual %0h",
				test_name, field, expected, actual));
	endtask

	////////////////////
	// Clock, timeout and bus models
	////////////////////

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("Simulation timed out after %0d cycles in %s",
				cycle_count, test_name));
	end

	// Grant, consumer and memory response driven after the edge
	always @(posedge clock) begin
		#1;
		read_command_bus_grant = grant_enable && read_command_bus_request &&
			!read_command_bus_grant;
		// With draining off the consumer probes only an empty buffer
		edge_data_request = drain_enable ? !data_buffer_empty :
			(data_buffer_empty && !edge_data_request);
		read_response_valid = 1'b0;
		if (mem_tag_q.size() > 0 && cycle_count >= mem_due_q[0] && !data_buffer_alfull) begin
			read_response_valid = 1'b1;
			read_response_tag   = mem_tag_q.pop_front();
			read_response_data  = build_line(mem_addr_q.pop_front());
			void'(mem_due_q.pop_front());
		end
	end

	// Command check and memory request capture
	always @(negedge clock) begin : command_monitor
		vertex_id_t dest;
		address_t   exp_address;
		if (rstn && read_command_valid) begin
			if (cmd_exp_q.size() == 0) begin
				fail_run("A read command was issued with no job outstanding");
			end else begin
				dest        = cmd_exp_q.pop_front();
				exp_address = BASE_ADDRESS + ((address_t'(dest) << 2) & ~address_t'(63));
				check_value("command address", exp_address, read_command_address);
				check_value("command tag", dest, read_command_tag);
				check_value("command code", exp_code, read_command_code);
				check_value("command cu_id", CU_ID, read_command_cu_id);
				mem_tag_q.push_back(read_command_tag);
				mem_addr_q.push_back(read_command_address);
				mem_due_q.push_back(cycle_count + 1 + ($unsigned($random(seed)) % 8));
			end
		end
	end

	// Edge data compared in job order
	always @(negedge clock) begin : data_compare
		vertex_id_t dest;
		if (rstn && edge_data_valid) begin
			if (data_exp_q.size() == 0) begin
				fail_run("Edge data arrived with no job outstanding");
			end else begin
				dest = data_exp_q.pop_front();
				check_value("edge data dest", dest, edge_data_dest);
				check_value("edge data word", expected_word(BASE_ADDRESS, dest),
					edge_data_word);
				data_seen++;
			end
		end
	end

	// Responses land in the data buffer two edges after they are seen
	always @(negedge clock) begin : level_model
		if (!rstn) begin
			data_level   = 0;
			resp_seen_d1 = 1'b0;
			resp_seen_d2 = 1'b0;
		end else begin
			if (resp_seen_d2)
				data_level++;
			if (edge_data_valid)
				data_level--;
			resp_seen_d2 = resp_seen_d1;
			resp_seen_d1 = read_response_valid;
			check_value("data buffer almost full",
				(JOB_BUFFER_DEPTH - data_level) < BUFFER_ALFULL_MARGIN, data_buffer_alfull);
			check_value("data buffer empty level", data_level == 0, data_buffer_empty);
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic issue_job(vertex_id_t dest);
		edge_job_valid = 1'b1;
		edge_job_dest  = dest;
		cmd_exp_q.push_back(dest);
		data_exp_q.push_back(dest);
		jobs_sent++;
	endtask

	task automatic send_job(vertex_id_t dest);
		while (!edge_request)
			step();
		issue_job(dest);
		step();
		edge_job_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (cmd_exp_q.size() > 0 || data_exp_q.size() > 0 || mem_tag_q.size() > 0)
			step();
		repeat (4) step();
		check_value("items delivered", jobs_sent, data_seen);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		seed                   = 60;
		cycle_count            = 0;
		jobs_sent              = 0;
		data_seen              = 0;
		grant_enable           = 1'b1;
		drain_enable           = 1'b1;
		saw_edge_request_low   = 1'b0;
		exp_code               = READ_CL_S;
		test_name              = "reset";
		rstn                   = 1'b0;
		enabled_in             = 1'b0;
		cu_configure           = '0;
		wed_base_valid         = 1'b1;
		wed_base               = BASE_ADDRESS;
		edge_job_valid         = 1'b0;
		edge_job_dest          = '0;
		read_command_bus_grant = 1'b0;
		read_response_valid    = 1'b0;
		read_response_tag      = '0;
		read_response_data     = '0;
		edge_data_request      = 1'b0;
		repeat (2) @(posedge clock);
		#1 rstn = 1'b1;

		test_name = "hold without enable";
		repeat (10) begin
			check_value("edge request", 0, edge_request);
			check_value("bus request", 0, read_command_bus_request);
			step();
		end

		// Enabled but configure still zero since reset
		test_name  = "hold without configure";
		enabled_in = 1'b1;
		for (int i = 0; i < 6; i++)
			send_job(vertex_id_t'(i * 7));
		repeat (20) begin
			check_value("bus request", 0, read_command_bus_request);
			step();
		end

		// Configured while disabled, pending jobs must wait
		test_name    = "hold with enable low";
		enabled_in   = 1'b0;
		exp_code     = READ_CL_S;
		cu_configure = 64'h2000;
		repeat (10) begin
			check_value("bus request", 0, read_command_bus_request);
			step();
		end
		enabled_in = 1'b1;
		wait_drained();

		// Zero word on the input keeps the shared bit set
		test_name    = "address and ordering";
		cu_configure = '0;
		for (int i = 0; i < 40; i++) begin
			if (i == 0)
				send_job(vertex_id_t'(0));
			else if (i == 1)
				send_job(vertex_id_t'(15));
			else
				send_job(vertex_id_t'($random(seed)));
			repeat ($unsigned($random(seed)) % 3) step();
		end
		wait_drained();

		// Shared bit clear, then a zero word that must keep it
		test_name    = "configure shared bit clear";
		exp_code     = READ_CL_NA;
		cu_configure = 64'h1;
		step();
		step();
		cu_configure = '0;
		step();
		for (int i = 0; i < 8; i++)
			send_job(vertex_id_t'($random(seed)));
		wait_drained();

		test_name    = "grant withheld";
		grant_enable = 1'b0;
		for (int i = 0; i < 45; i++) begin
			if (i == 30)
				grant_enable = 1'b1;
			if (!edge_request)
				saw_edge_request_low = 1'b1;
			if (i >= 8 && i < 30)
				check_value("bus request held", 1, read_command_bus_request);
			if (edge_request)
				issue_job(vertex_id_t'($random(seed)));
			else
				edge_job_valid = 1'b0;
			step();
		end
		edge_job_valid = 1'b0;
		if (!saw_edge_request_low)
			fail_run("Edge request never fell while grants were withheld");
		wait_drained();

		// Consumer held so the data buffer fills to its margin
		test_name    = "data buffer almost full";
		drain_enable = 1'b0;
		for (int i = 0; i < 16; i++)
			send_job(vertex_id_t'($random(seed)));
		while (!data_buffer_alfull)
			step();
		repeat (4) step();
		drain_enable = 1'b1;
		wait_drained();

		test_name    = "request on empty buffer";
		drain_enable = 1'b0;
		repeat (12) begin
			check_value("data buffer empty", 1, data_buffer_empty);
			step();
		end
		drain_enable = 1'b1;
		repeat (4) step();
		check_value("items delivered", jobs_sent, data_seen);

		if (dut_i.assertions_i.failure_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("%0d assertion failures were raised", dut_i.assertions_i.failure_count);
			$display("Test failures found");
			$fatal(1, "Simulation stopped");
		end
	end

endmodule

/* list.f */
verilog/edge_data_pkg.sv
verilog/sync_fifo.sv
verilog/edge_data_control.sv
verilog/edge_data_response.sv
verilog/cu_edge_data_top.sv
sim/cu_edge_data_assertions.sv
sim/tb_cu_edge_data.sv

/* Bender.yml */
package:
  name: cu_edge_data

sources:
  - verilog/edge_data_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/edge_data_control.sv
  - verilog/edge_data_response.sv
  - verilog/cu_edge_data_top.sv
  - target: simulation
    files:
      - sim/cu_edge_data_assertions.sv
      - sim/tb_cu_edge_data.sv
